// File: src/distribute_in_macros.svh
`ifndef DISTRIBUTE_IN_MACROS_SVH
`define DISTRIBUTE_IN_MACROS_SVH

// activation side
`define DIST_NUM_ACT_IN 4        // activation ports, one fifo each
`define DIST_GROUP_SIZE 4        // lanes per activation group
`define DIST_DATA_WIDTH 8        // bits per lane or per weight

// output side
// also the number of weights in one row
`define DIST_NUM_OUT 4

// configuration counters
`define DIST_ITER_BITS 16        // iteration count width
`define DIST_READS_BITS 16       // reads per iteration width

// input buffering
`define DIST_FIFO_SLOTS 4        // depth of every input fifo

// derived word widths
`define DIST_GROUP_BITS (`DIST_GROUP_SIZE * `DIST_DATA_WIDTH)   // one activation group
`define DIST_ROW_BITS (`DIST_NUM_OUT * `DIST_DATA_WIDTH)        // one weight row

`endif

// File: src/distribute_pkg.sv
`default_nettype none

`include "distribute_in_macros.svh"

package distribute_pkg;

  // distribution mode, picked at configure time
  typedef enum logic {
    MODE_BROADCAST = 1'b0,   // port 0 copied to every output
    MODE_DIRECT    = 1'b1    // port i to output i
  } conf_mode_e;

  // one group of lanes from an activation port
  typedef logic [`DIST_GROUP_BITS-1:0] act_group_t;

  // one weight per output, lane 0 in the low byte
  typedef logic [`DIST_ROW_BITS-1:0] weight_row_t;

  // iteration count as loaded by configure
  typedef logic [`DIST_ITER_BITS-1:0] iter_cnt_t;

  // reads per iteration as loaded by configure
  typedef logic [`DIST_READS_BITS-1:0] read_cnt_t;

endpackage

`default_nettype wire

// File: src/iter_if.sv
`timescale 1ns/100ps
`default_nettype none

// link between the iteration register block and the dispatch logic
interface iter_if
  import distribute_pkg::*;
();

  conf_mode_e mode;        // registered mode
  logic       enabled;     // still reads left in the run
  logic       first_read;  // on read 1 of the current iteration
  logic       fire;        // a read happens this cycle

  // register side, owns the counters
  modport cfg (
    output mode,
    output enabled,
    output first_read,
    input  fire
  );

  // read decision side
  modport disp (
    input  mode,
    input  enabled,
    input  first_read,
    output fire
  );

endinterface

`default_nettype wire

// File: src/dist_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "distribute_in_macros.svh"

// first word fall through, head visible while not empty
module dist_fifo #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             write,        // push on this edge
  input  logic [WIDTH-1:0] write_data,
  output logic             full,
  output logic             almost_full,  // one slot left
  output logic [WIDTH-1:0] read_data,    // oldest entry
  input  logic             next_read,    // pop on this edge
  output logic             empty
);

  localparam int PTR_BITS = $clog2(`DIST_FIFO_SLOTS);
  localparam int CNT_BITS = $clog2(`DIST_FIFO_SLOTS + 1);

  logic [WIDTH-1:0]    mem [`DIST_FIFO_SLOTS];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;   // entries held
  logic                do_write;
  logic                do_read;

  assign do_write = write & ~full;       // overflow is dropped
  assign do_read  = next_read & ~empty;

  // storage
  always_ff @(posedge clk) begin
    if (do_write) mem[wr_ptr] <= write_data;
  end

  assign read_data = mem[rd_ptr];

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (!rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        if (wr_ptr == PTR_BITS'(`DIST_FIFO_SLOTS - 1)) wr_ptr <= '0;   // wrap
        else wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        if (rd_ptr == PTR_BITS'(`DIST_FIFO_SLOTS - 1)) rd_ptr <= '0;
        else rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // both or neither
      endcase
    end
  end

  assign full        = (count == CNT_BITS'(`DIST_FIFO_SLOTS));
  assign almost_full = (count == CNT_BITS'(`DIST_FIFO_SLOTS - 1));
  assign empty       = (count == '0);

  // the writer is supposed to watch avail upstream
  no_write_when_full: assert property (@(posedge clk) disable iff (!rst) !(write && full))
    else $error("dist_fifo write while full");

  // dispatch only pops fifos it saw non-empty
  no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst) !(next_read && empty))
    else $error("dist_fifo pop while empty");

endmodule

`default_nettype wire

// File: src/iter_config.sv
`timescale 1ns/100ps
`default_nettype none

// mode register plus iteration and read down counters
module iter_config
  import distribute_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       configure,   // load pulse
  input  conf_mode_e conf_mode,
  input  iter_cnt_t  num_iters,   // must not be zero
  input  read_cnt_t  num_reads,   // must not be zero
  iter_if.cfg        cfg
);

  conf_mode_e mode_q;
  logic       enabled_q;
  iter_cnt_t  iters_left;     // iterations still to run, current one included
  read_cnt_t  reads_left;     // reads still to do in this iteration
  read_cnt_t  reads_reload;   // copy of num_reads for the next iteration
  logic       last_read;
  logic       last_iter;

  assign last_read = (reads_left == read_cnt_t'(1));
  assign last_iter = (iters_left == iter_cnt_t'(1));

  always_ff @(posedge clk) begin
    if (!rst) begin
      mode_q       <= MODE_BROADCAST;
      enabled_q    <= 1'b0;
      iters_left   <= '0;
      reads_left   <= '0;
      reads_reload <= '0;
    end else if (configure) begin
      // configure wins over a read in the same cycle
      mode_q       <= conf_mode;
      enabled_q    <= 1'b1;
      iters_left   <= num_iters;
      reads_left   <= num_reads;
      reads_reload <= num_reads;
    end else if (cfg.fire) begin
      if (last_read) begin
        reads_left <= reads_reload;   // rearm for next iteration
        if (last_iter) begin
          enabled_q <= 1'b0;          // run finished
        end else begin
          iters_left <= iters_left - 1'b1;
        end
      end else begin
        reads_left <= reads_left - 1'b1;
      end
    end
  end

  assign cfg.mode       = mode_q;
  assign cfg.enabled    = enabled_q;
  // full read budget left means nothing consumed yet
  assign cfg.first_read = enabled_q & (reads_left == reads_reload);

  // a zero count would never reach the last read
  nonzero_counts: assert property (
    @(posedge clk) disable iff (!rst)
    configure |-> (num_iters != '0) && (num_reads != '0)
  ) else $error("iter_config configure with a zero count");

endmodule

`default_nettype wire

// File: src/dispatch_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "distribute_in_macros.svh"

// read decision and output steering, purely combinational
module dispatch_ctrl
  import distribute_pkg::*;
(
  iter_if.disp                        disp,
  input  act_group_t                  act_head [`DIST_NUM_ACT_IN],   // fifo heads
  input  logic [`DIST_NUM_ACT_IN-1:0] act_empty,
  input  weight_row_t                 weight_head,
  input  logic                        weight_empty,
  input  logic [`DIST_NUM_OUT-1:0]    out_avail,
  input  logic [`DIST_NUM_OUT-1:0]    weight_out_avail,
  output logic [`DIST_NUM_ACT_IN-1:0] act_pop,
  output logic                        weight_pop,
  output act_group_t                  out_data [`DIST_NUM_OUT],
  output logic [`DIST_NUM_OUT-1:0]    out_valid,
  output weight_row_t                 weight_data,
  output logic [`DIST_NUM_OUT-1:0]    weight_out_valid
);

  logic                        direct;        // mode 1 decoded
  logic [`DIST_NUM_ACT_IN-1:0] act_need;      // fifos taking part in a read
  logic                        act_ready;
  logic                        outs_ready;
  logic                        weight_ready;
  logic                        fire_w;

  assign direct = (disp.mode == MODE_DIRECT);

  // broadcast only looks at fifo 0
  assign act_need = direct ? {`DIST_NUM_ACT_IN{1'b1}} : `DIST_NUM_ACT_IN'(1);

  assign act_ready = ~|(act_need & act_empty);   // every needed head present

  // every output must take the group, none may miss it
  assign outs_ready = &out_avail;

  // weight path only matters on the first read
  assign weight_ready = ~weight_empty & (&weight_out_avail);

  assign fire_w = disp.enabled & outs_ready & act_ready &
                  (~disp.first_read | weight_ready);

  assign disp.fire = fire_w;

  // pops
  assign act_pop    = {`DIST_NUM_ACT_IN{fire_w}} & act_need;
  assign weight_pop = fire_w & disp.first_read;

  // steering, direct mode relies on one port per output
  for (genvar i = 0; i < `DIST_NUM_OUT; i++) begin : g_steer
    assign out_data[i] = direct ? act_head[i] : act_head[0];
  end

  assign out_valid        = {`DIST_NUM_OUT{fire_w}};
  assign weight_data      = weight_head;   // fifo head, qualified by valid
  assign weight_out_valid = {`DIST_NUM_OUT{weight_pop}};

endmodule

`default_nettype wire

// File: src/distribute_in.sv
`timescale 1ns/100ps
`default_nettype none

`include "distribute_in_macros.svh"

// activation and weight distributor, flat ports
module distribute_in
  import distribute_pkg::*;
(
  input  logic                                         clk,
  input  logic                                         rst,

  // configuration
  input  logic                                         configure,
  input  conf_mode_e                                   conf_mode,
  input  iter_cnt_t                                    num_iters,
  input  read_cnt_t                                    num_reads,

  // activation inputs, port i in group slot i
  input  logic [`DIST_NUM_ACT_IN*`DIST_GROUP_BITS-1:0] act_data,
  input  logic [`DIST_NUM_ACT_IN-1:0]                  act_valid,
  output logic [`DIST_NUM_ACT_IN-1:0]                  act_avail,

  // weight row input
  input  logic [`DIST_ROW_BITS-1:0]                    weight_data_in,
  input  logic                                         weight_valid,
  output logic                                         weight_avail,

  // activation outputs
  output logic [`DIST_NUM_OUT*`DIST_GROUP_BITS-1:0]    out_data,
  output logic [`DIST_NUM_OUT-1:0]                     out_valid,
  input  logic [`DIST_NUM_OUT-1:0]                     out_avail,

  // weight outputs, same row to every output
  output logic [`DIST_ROW_BITS-1:0]                    weight_out_data,
  output logic [`DIST_NUM_OUT-1:0]                     weight_out_valid,
  input  logic [`DIST_NUM_OUT-1:0]                     weight_out_avail
);

  act_group_t                  act_head [`DIST_NUM_ACT_IN];   // fifo heads
  logic [`DIST_NUM_ACT_IN-1:0] act_full;
  logic [`DIST_NUM_ACT_IN-1:0] act_almost_full;
  logic [`DIST_NUM_ACT_IN-1:0] act_empty;
  logic [`DIST_NUM_ACT_IN-1:0] act_pop;

  weight_row_t weight_head;
  logic        weight_full;
  logic        weight_almost_full;
  logic        weight_empty;
  logic        weight_pop;

  act_group_t out_grp [`DIST_NUM_OUT];   // steered groups before packing

  iter_if iter_bus ();

  // one fifo per activation port
  for (genvar i = 0; i < `DIST_NUM_ACT_IN; i++) begin : g_act
    dist_fifo #(
      .WIDTH       ($bits(act_group_t))
    ) u_act_fifo (
      .clk         (clk),
      .rst         (rst),
      .write       (act_valid[i]),
      .write_data  (act_data[i*`DIST_GROUP_BITS +: `DIST_GROUP_BITS]),
      .full        (act_full[i]),
      .almost_full (act_almost_full[i]),
      .read_data   (act_head[i]),
      .next_read   (act_pop[i]),
      .empty       (act_empty[i])
    );

    // keeps a slot spare for a write already in flight
    assign act_avail[i] = ~act_full[i] & ~act_almost_full[i];
  end

  // all weight rows share one fifo
  dist_fifo #(
    .WIDTH       ($bits(weight_row_t))
  ) u_weight_fifo (
    .clk         (clk),
    .rst         (rst),
    .write       (weight_valid),
    .write_data  (weight_data_in),
    .full        (weight_full),
    .almost_full (weight_almost_full),
    .read_data   (weight_head),
    .next_read   (weight_pop),
    .empty       (weight_empty)
  );

  assign weight_avail = ~weight_full & ~weight_almost_full;

  iter_config u_iter_config (
    .clk       (clk),
    .rst       (rst),
    .configure (configure),
    .conf_mode (conf_mode),
    .num_iters (num_iters),
    .num_reads (num_reads),
    .cfg       (iter_bus.cfg)
  );

  dispatch_ctrl u_dispatch_ctrl (
    .disp             (iter_bus.disp),
    .act_head         (act_head),
    .act_empty        (act_empty),
    .weight_head      (weight_head),
    .weight_empty     (weight_empty),
    .out_avail        (out_avail),
    .weight_out_avail (weight_out_avail),
    .act_pop          (act_pop),
    .weight_pop       (weight_pop),
    .out_data         (out_grp),
    .out_valid        (out_valid),
    .weight_data      (weight_out_data),
    .weight_out_valid (weight_out_valid)
  );

  // pack steered groups back into the flat bus
  for (genvar i = 0; i < `DIST_NUM_OUT; i++) begin : g_out
    assign out_data[i*`DIST_GROUP_BITS +: `DIST_GROUP_BITS] = out_grp[i];
  end

endmodule

`default_nettype wire

// File: verif/tb_distribute_in.sv
`timescale 1ns/100ps
`default_nettype none

`include "distribute_in_macros.svh"

module tb_distribute_in
  import distribute_pkg::*;
();

  localparam int GB = `DIST_GROUP_BITS;
  localparam int LIMIT = 400;                                // cycles allowed per wait
  localparam int TEST_CYCLES = 10 + 2 * LIMIT + 20 + 2 * LIMIT + 20 + LIMIT;
  localparam int WATCHDOG_NS = 2 * 4 * (8 + TEST_CYCLES);   // margin of two

  logic clk;
  logic rst;
  logic configure;
  conf_mode_e conf_mode;
  iter_cnt_t num_iters;
  read_cnt_t num_reads;
  logic [`DIST_NUM_ACT_IN*GB-1:0] act_data;
  logic [`DIST_NUM_ACT_IN-1:0] act_valid;
  logic [`DIST_NUM_ACT_IN-1:0] act_avail;
  logic [`DIST_ROW_BITS-1:0] weight_data_in;
  logic weight_valid;
  logic weight_avail;
  logic [`DIST_NUM_OUT*GB-1:0] out_data;
  logic [`DIST_NUM_OUT-1:0] out_valid;
  logic [`DIST_NUM_OUT-1:0] out_avail;
  logic [`DIST_ROW_BITS-1:0] weight_out_data;
  logic [`DIST_NUM_OUT-1:0] weight_out_valid;
  logic [`DIST_NUM_OUT-1:0] weight_out_avail;

  // stimulus knobs, set by the tests
  logic [`DIST_NUM_ACT_IN-1:0] push_act;
  logic push_weight;
  logic random_bp;                     // random low bits on the avail inputs
  logic cfg_pulse;
  conf_mode_e cfg_mode;
  iter_cnt_t cfg_iters;
  read_cnt_t cfg_reads;

  // reference model
  act_group_t act_q [`DIST_NUM_ACT_IN][$];   // mirrors each activation fifo
  weight_row_t wq [$];
  logic mdl_enabled;
  conf_mode_e mdl_mode;
  int mdl_iters;
  int mdl_reads;
  int iters_done;
  int reads_done;                      // reads in current iteration

  logic [31:0] lfsr;
  int errors;
  int fires_total;                     // reads seen at the DUT outputs
  int weight_fires;                    // weight rows seen at the DUT outputs
  int tests_run;
  int tests_failed;
  logic avail_low_seen;

  distribute_in u_distribute_in (.*);

  always #2 clk = ~clk;   // 4 ns period

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic b;
    r = '0;
    for (int k = 0; k < n; k++) begin
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ 32'h8020_0003;
      r = {r[30:0], b};
    end
    return r;
  endfunction

  task automatic check_group(input act_group_t got, input act_group_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_row(input weight_row_t got, input weight_row_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input bit got, input bit exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // drive on the falling edge, check 1 ns later and update the model
  task automatic run_cycle();
    logic fire_exp;
    logic first_exp;
    logic wrote_w;
    logic [`DIST_NUM_ACT_IN-1:0] need;
    logic [`DIST_NUM_ACT_IN-1:0] wrote;
    act_group_t new_grp [`DIST_NUM_ACT_IN];
    weight_row_t new_row;
    act_group_t exp_grp;
    @(negedge clk);
    for (int i = 0; i < `DIST_NUM_ACT_IN; i++) begin
      check_flag(act_avail[i], act_q[i].size() < 3, "act_avail");   // low from 3 entries
      wrote[i] = push_act[i] & act_avail[i];                     // write only while avail
      new_grp[i] = wrote[i] ? act_group_t'(rand_bits(GB)) : '0;
      act_data[i*GB +: GB] = new_grp[i];
    end
    if (!act_avail[0]) avail_low_seen = 1'b1;
    act_valid = wrote;
    check_flag(weight_avail, wq.size() < 3, "weight_avail");
    wrote_w = push_weight & weight_avail;
    new_row = wrote_w ? weight_row_t'(rand_bits(`DIST_ROW_BITS)) : '0;
    weight_data_in = new_row;
    weight_valid = wrote_w;
    configure = cfg_pulse;
    conf_mode = cfg_mode;
    num_iters = cfg_iters;
    num_reads = cfg_reads;
    for (int j = 0; j < `DIST_NUM_OUT; j++) begin
      out_avail[j] = random_bp ? |rand_bits(2) : 1'b1;   // low one time in four
      weight_out_avail[j] = random_bp ? |rand_bits(2) : 1'b1;
    end
    #1;
    // read rule
    need = (mdl_mode == MODE_DIRECT) ? '1 : `DIST_NUM_ACT_IN'(1);
    first_exp = mdl_enabled && (reads_done == 0);
    fire_exp = mdl_enabled && (&out_avail);
    for (int i = 0; i < `DIST_NUM_ACT_IN; i++) begin
      if (need[i] && act_q[i].size() == 0) fire_exp = 1'b0;
    end
    if (first_exp && (wq.size() == 0 || !(&weight_out_avail))) fire_exp = 1'b0;
    for (int j = 0; j < `DIST_NUM_OUT; j++) begin
      check_flag(out_valid[j], fire_exp, "out_valid");
      check_flag(weight_out_valid[j], fire_exp && first_exp, "weight_out_valid");
    end
    if (|out_valid) fires_total++;
    if (|weight_out_valid) weight_fires++;
    if (fire_exp) begin
      for (int j = 0; j < `DIST_NUM_OUT; j++) begin
        exp_grp = (mdl_mode == MODE_DIRECT) ? act_q[j][0] : act_q[0][0];
        check_group(out_data[j*GB +: GB], exp_grp, "out_data");
      end
      if (first_exp) begin
        check_row(weight_out_data, wq[0], "weight_out_data");
        void'(wq.pop_front());
      end
      for (int i = 0; i < `DIST_NUM_ACT_IN; i++) begin
        if (need[i]) void'(act_q[i].pop_front());
      end
    end
    if (cfg_pulse) begin   // load beats the count update
      mdl_enabled = 1'b1;
      mdl_mode = cfg_mode;
      mdl_iters = cfg_iters;
      mdl_reads = cfg_reads;
      iters_done = 0;
      reads_done = 0;
    end else if (fire_exp) begin
      reads_done++;
      if (reads_done == mdl_reads) begin
        reads_done = 0;
        iters_done++;
        if (iters_done == mdl_iters) mdl_enabled = 1'b0;
      end
    end
    for (int i = 0; i < `DIST_NUM_ACT_IN; i++) begin
      if (wrote[i]) act_q[i].push_back(new_grp[i]);
    end
    if (wrote_w) wq.push_back(new_row);
  endtask

  task automatic run_cycles(input int n);
    repeat (n) run_cycle();
  endtask

  task automatic load_config(input conf_mode_e mode, input int iters, input int reads);
    cfg_mode = mode;
    cfg_iters = iter_cnt_t'(iters);
    cfg_reads = read_cnt_t'(reads);
    cfg_pulse = 1'b1;
    run_cycle();
    cfg_pulse = 1'b0;
  endtask

  task automatic wait_fires(input int target, input string what);
    int n;
    n = 0;
    while (fires_total < target && n < LIMIT) begin
      run_cycle();
      n++;
    end
    if (fires_total < target) begin
      errors++;
      $display("%s: the expected reads did not happen within %0d cycles", what, LIMIT);
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", name, errors - err_start);
    end
  endtask

  task automatic test_reset_state();
    int e0;
    e0 = errors;
    run_cycles(2);   // idle, nothing valid
    push_act = '1;   // one entry per port, no configure
    push_weight = 1'b1;
    run_cycle();
    push_act = '0;
    push_weight = 1'b0;
    run_cycles(4);
    report_test("reset_state", e0);
  endtask

  task automatic test_broadcast();
    int e0;
    int f0;
    int w0;
    e0 = errors;
    f0 = fires_total;
    w0 = weight_fires;
    load_config(MODE_BROADCAST, 2, 3);
    push_act = 4'b0001;
    push_weight = 1'b1;
    wait_fires(f0 + 6, "broadcast");
    push_act = '0;
    push_weight = 1'b0;
    run_cycles(4);   // run over, nothing more may come out
    check_flag(fires_total == f0 + 6, 1'b1, "broadcast read count");
    check_flag(weight_fires == w0 + 2, 1'b1, "broadcast weight row count");
    report_test("broadcast", e0);
  endtask

  task automatic test_direct();
    int e0;
    int s0;
    int f0;
    e0 = errors;
    s0 = fires_total;
    load_config(MODE_DIRECT, 2, 2);
    push_act = 4'b0111;   // port 3 starved
    push_weight = 1'b1;
    run_cycles(8);
    // port 3 held one group from the reset test
    check_flag(fires_total == s0 + 1, 1'b1, "one direct read before port 3 ran dry");
    f0 = fires_total;
    run_cycles(4);
    check_flag(fires_total == f0, 1'b1, "direct stall while a fifo is empty");
    push_act = '1;
    wait_fires(f0 + 3, "direct");   // one read was taken before the stall
    push_act = '0;
    push_weight = 1'b0;
    run_cycles(3);
    report_test("direct", e0);
  endtask

  task automatic test_iteration_end();
    int e0;
    int f0;
    e0 = errors;
    f0 = fires_total;
    load_config(MODE_DIRECT, 1, 2);
    push_act = '1;
    push_weight = 1'b1;
    wait_fires(f0 + 2, "iteration end");
    run_cycles(6);   // fifos fill while disabled
    check_flag(fires_total == f0 + 2, 1'b1, "no read after the last iteration");
    check_flag(act_avail[1], 1'b0, "act_avail with data queued after the run");
    push_act = '0;
    push_weight = 1'b0;
    load_config(MODE_DIRECT, 1, 3);   // resume drains the queue in order
    wait_fires(f0 + 5, "resume");
    report_test("iteration_end", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    int f0;
    e0 = errors;
    f0 = fires_total;
    avail_low_seen = 1'b0;
    load_config(MODE_BROADCAST, 3, 4);
    random_bp = 1'b1;
    push_act = 4'b0001;
    push_weight = 1'b1;
    wait_fires(f0 + 12, "back-pressure");
    random_bp = 1'b0;
    push_act = '0;
    push_weight = 1'b0;
    run_cycles(3);
    if (!avail_low_seen) begin
      errors++;
      $display("act_avail on port 0 never dropped under back-pressure");
    end
    report_test("backpressure", e0);
  endtask

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst = 1'b0;
    configure = 1'b0;
    conf_mode = MODE_BROADCAST;
    num_iters = '0;
    num_reads = '0;
    act_data = '0;
    act_valid = '0;
    weight_data_in = '0;
    weight_valid = 1'b0;
    out_avail = '1;
    weight_out_avail = '1;
    push_act = '0;
    push_weight = 1'b0;
    random_bp = 1'b0;
    cfg_pulse = 1'b0;
    cfg_mode = MODE_BROADCAST;
    cfg_iters = '0;
    cfg_reads = '0;
    mdl_enabled = 1'b0;
    mdl_mode = MODE_BROADCAST;
    mdl_iters = 0;
    mdl_reads = 0;
    iters_done = 0;
    reads_done = 0;
    lfsr = 32'h361f38f2;
    errors = 0;
    fires_total = 0;
    weight_fires = 0;
    tests_run = 0;
    tests_failed = 0;
    avail_low_seen = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b1;   // release between edges
    test_reset_state();
    test_broadcast();
    test_direct();
    test_iteration_end();
    test_backpressure();
    $display("tests run %0d, failed %0d, errors %0d, reads %0d", tests_run, tests_failed,
             errors, fires_total);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: distribute_in.f
+incdir+src
src/distribute_pkg.sv
src/iter_if.sv
src/dist_fifo.sv
src/iter_config.sv
src/dispatch_ctrl.sv
src/distribute_in.sv
verif/tb_distribute_in.sv

// File: Bender.yml
package:
  name: distribute_in

sources:
  - include_dirs:
      - src
    files:
      - src/distribute_pkg.sv
      - src/iter_if.sv
      - src/dist_fifo.sv
      - src/iter_config.sv
      - src/dispatch_ctrl.sv
      - src/distribute_in.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/tb_distribute_in.sv
